// File: source/pcie_app_pkg.sv
package pcie_app_pkg;

   typedef logic [63:0] qword_t;
   // requester id above tag
   typedef logic [23:0] rid_tag_t;
   // qword register address, byte address bits 15:3
   typedef logic [12:0] reg_addr_t;
   // bus, device, function
   typedef logic [15:0] pcie_id_t;

   // fmt/type byte of header DW0
   localparam logic [7:0] FMT_MWR32 = 8'h40;
   localparam logic [7:0] FMT_MRD32 = 8'h00;
   localparam logic [7:0] FMT_CPLD  = 8'h4A;
   localparam logic [7:0] FMT_MWR64 = 8'h60;
   localparam logic [7:0] FMT_MRD64 = 8'h20;

   // register map
   localparam reg_addr_t REG_SCRATCH      = 13'd0;
   localparam reg_addr_t REG_CPLD_COUNT   = 13'd1;
   localparam reg_addr_t REG_WRITE_COUNT  = 13'd2;
   localparam reg_addr_t REG_READ_COUNT   = 13'd3;
   localparam reg_addr_t REG_WRITE_LAUNCH = 13'd100;
   localparam reg_addr_t REG_READ_LAUNCH  = 13'd101;

   localparam logic [31:0] UNMAPPED_PATTERN = 32'hDEADBEEF;
   localparam qword_t      WRITE_DATA_START = 64'h100;

   typedef enum logic [1:0]
   {
      RX_HEADER,
      RX_ADDRESS,
      RX_DATA,
      RX_DROP
   } rx_state_t;

   typedef enum logic [1:0]
   {
      TX_IDLE,
      TX_BEAT0,
      TX_BEAT1,
      TX_BEAT2
   } tx_state_t;

endpackage

// File: source/tlp_receiver.sv
`timescale 1ns/10ps

module tlp_receiver
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    rx_tvalid,
   input  logic                    rx_tlast,
   input  pcie_app_pkg::qword_t    rx_tdata,
   output logic                    write_valid,
   output logic                    read_valid,
   output logic                    completion_valid,
   output pcie_app_pkg::reg_addr_t address,
   output pcie_app_pkg::qword_t    data,
   output pcie_app_pkg::rid_tag_t  rid_tag
);

   pcie_app_pkg::rx_state_t state;
   logic [7:0] fmt_type;
   logic [7:0] rx_fmt;
   logic       rx_known;
   logic       is_write;
   logic       is_read;
   logic       is_cpl;
   logic       end_of_tlp;

   assign rx_fmt = rx_tdata[31:24];
   assign rx_known = rx_fmt == pcie_app_pkg::FMT_MWR32 ||
                     rx_fmt == pcie_app_pkg::FMT_MRD32 ||
                     rx_fmt == pcie_app_pkg::FMT_CPLD;

   assign is_write = fmt_type == pcie_app_pkg::FMT_MWR32;
   assign is_read  = fmt_type == pcie_app_pkg::FMT_MRD32;
   assign is_cpl   = fmt_type == pcie_app_pkg::FMT_CPLD;

   // last beat of a decoded packet
   assign end_of_tlp = rx_tvalid && rx_tlast &&
                       (state == pcie_app_pkg::RX_ADDRESS || state == pcie_app_pkg::RX_DATA);

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state <= pcie_app_pkg::RX_HEADER;
         write_valid <= 1'b0;
         read_valid <= 1'b0;
         completion_valid <= 1'b0;
      end
      else
      begin
         write_valid <= end_of_tlp && is_write;
         read_valid <= end_of_tlp && is_read;
         completion_valid <= end_of_tlp && is_cpl;
         if (rx_tvalid)
         begin
            case (state)
               pcie_app_pkg::RX_HEADER:
               begin
                  if (!rx_tlast)
                     state <= rx_known ? pcie_app_pkg::RX_ADDRESS : pcie_app_pkg::RX_DROP;
               end
               pcie_app_pkg::RX_ADDRESS:
               begin
                  state <= rx_tlast ? pcie_app_pkg::RX_HEADER : pcie_app_pkg::RX_DATA;
               end
               default:
               begin
                  if (rx_tlast)
                     state <= pcie_app_pkg::RX_HEADER;
               end
            endcase
         end
      end
   end

   // header fields and straddled payload
   always_ff @(posedge clock)
   begin
      if (rx_tvalid)
      begin
         case (state)
            pcie_app_pkg::RX_HEADER:
            begin
               fmt_type <= rx_fmt;
               rid_tag <= rx_tdata[63:40];
            end
            pcie_app_pkg::RX_ADDRESS:
            begin
               // completions carry requester id and tag in DW2
               if (is_cpl)
                  rid_tag <= rx_tdata[31:8];
               else
                  address <= rx_tdata[15:3];
               data[31:0] <= rx_tdata[63:32];
            end
            pcie_app_pkg::RX_DATA:
            begin
               data[63:32] <= rx_tdata[31:0];
            end
            default:
            begin
            end
         endcase
      end
   end

endmodule

// File: source/bar_registers.sv
`timescale 1ns/10ps

module bar_registers
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    write_valid,
   input  logic                    read_valid,
   input  logic                    completion_valid,
   input  pcie_app_pkg::reg_addr_t address,
   input  pcie_app_pkg::qword_t    data,
   input  pcie_app_pkg::rid_tag_t  rid_tag,
   input  logic                    read_completion_ready,
   input  logic                    write_request_ready,
   input  logic                    write_request_accepted,
   input  logic                    read_request_ready,
   output logic [3:0]              led,
   output logic                    read_completion_valid,
   output pcie_app_pkg::rid_tag_t  read_completion_rid_tag,
   output logic [3:0]              read_completion_lower_addr,
   output pcie_app_pkg::qword_t    read_completion_data,
   output logic                    write_request_valid,
   output pcie_app_pkg::qword_t    write_request_address,
   output pcie_app_pkg::qword_t    write_request_data,
   output logic                    read_request_valid,
   output pcie_app_pkg::qword_t    read_request_address
);

   logic [15:0]             cpld_count;
   logic [15:0]             write_count;
   logic [15:0]             read_count;
   pcie_app_pkg::qword_t    scratch;
   pcie_app_pkg::qword_t    read_data;
   pcie_app_pkg::reg_addr_t read_address;
   pcie_app_pkg::rid_tag_t  read_rid_tag;
   logic                    read_done;
   logic                    write_launch;
   logic                    read_launch;

   assign write_launch = write_valid && address == pcie_app_pkg::REG_WRITE_LAUNCH;
   assign read_launch  = write_valid && address == pcie_app_pkg::REG_READ_LAUNCH;

   // selected one cycle after read_valid, so counters already include it
   always_comb
   begin
      case (read_address)
         pcie_app_pkg::REG_SCRATCH:     read_data = scratch;
         pcie_app_pkg::REG_CPLD_COUNT:  read_data = {48'h0, cpld_count};
         pcie_app_pkg::REG_WRITE_COUNT: read_data = {48'h0, write_count};
         pcie_app_pkg::REG_READ_COUNT:  read_data = {48'h0, read_count};
         default: read_data = {19'h0, read_address, pcie_app_pkg::UNMAPPED_PATTERN};
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         led <= 4'h5;
         scratch <= '0;
         cpld_count <= '0;
         write_count <= '0;
         read_count <= '0;
         read_done <= 1'b0;
         read_completion_valid <= 1'b0;
         write_request_valid <= 1'b0;
         read_request_valid <= 1'b0;
         write_request_data <= pcie_app_pkg::WRITE_DATA_START;
      end
      else
      begin
         if (write_valid)
            led <= data[3:0];
         if ((write_valid && address == pcie_app_pkg::REG_SCRATCH) || completion_valid)
            scratch <= data;
         cpld_count <= cpld_count + 16'(completion_valid);
         write_count <= write_count + 16'(write_valid);
         read_count <= read_count + 16'(read_valid);
         read_done <= read_valid;

         if (read_done)
            read_completion_valid <= 1'b1;
         else if (read_completion_ready)
            read_completion_valid <= 1'b0;

         if (write_launch)
            write_request_valid <= 1'b1;
         else if (write_request_ready)
            write_request_valid <= 1'b0;

         if (read_launch)
            read_request_valid <= 1'b1;
         else if (read_request_ready)
            read_request_valid <= 1'b0;

         write_request_data <= write_request_data + 64'(write_request_accepted);
      end
   end

   always_ff @(posedge clock)
   begin
      // receiver fields may change before the return
      if (read_valid)
      begin
         read_address <= address;
         read_rid_tag <= rid_tag;
      end
      if (read_done)
      begin
         read_completion_rid_tag <= read_rid_tag;
         read_completion_lower_addr <= read_address[3:0];
         read_completion_data <= read_data;
      end
      if (write_launch)
         write_request_address <= data;
      if (read_launch)
         read_request_address <= data;
   end

endmodule

// File: source/tlp_transmitter.sv
`timescale 1ns/10ps

module tlp_transmitter
(
   input  logic                    clock,
   input  logic                    reset,
   input  pcie_app_pkg::pcie_id_t  pcie_id,
   input  logic                    read_completion_valid,
   input  pcie_app_pkg::rid_tag_t  read_completion_rid_tag,
   input  logic [3:0]              read_completion_lower_addr,
   input  pcie_app_pkg::qword_t    read_completion_data,
   output logic                    read_completion_ready,
   input  logic                    write_request_valid,
   input  pcie_app_pkg::qword_t    write_request_address,
   input  pcie_app_pkg::qword_t    write_request_data,
   output logic                    write_request_ready,
   output logic                    write_request_accepted,
   input  logic                    read_request_valid,
   input  pcie_app_pkg::qword_t    read_request_address,
   output logic                    read_request_ready,
   input  logic                    tx_tready,
   output logic                    tx_tvalid,
   output logic                    tx_tlast,
   output pcie_app_pkg::qword_t    tx_tdata,
   output logic [7:0]              tx_tkeep
);

   pcie_app_pkg::tx_state_t state;
   pcie_app_pkg::qword_t    beat0;
   pcie_app_pkg::qword_t    beat1;
   pcie_app_pkg::qword_t    beat2;
   logic                    idle;
   logic                    two_beats;
   logic                    half_last;
   logic                    sending_write;
   logic [31:0]             request_dw1;

   assign idle = state == pcie_app_pkg::TX_IDLE;

   // fixed priority: completion, write, read
   assign read_completion_ready = idle && read_completion_valid;
   assign write_request_ready = idle && write_request_valid && !read_completion_valid;
   assign read_request_ready = idle && read_request_valid && !read_completion_valid &&
                               !write_request_valid;

   // requester id, tag 0, all byte enables
   assign request_dw1 = {pcie_id, 16'h00FF};

   always_ff @(posedge clock)
   begin
      if (reset)
         state <= pcie_app_pkg::TX_IDLE;
      else
      begin
         case (state)
            pcie_app_pkg::TX_IDLE:
            begin
               if (read_completion_valid || write_request_valid || read_request_valid)
                  state <= pcie_app_pkg::TX_BEAT0;
            end
            pcie_app_pkg::TX_BEAT0:
            begin
               if (tx_tready)
                  state <= pcie_app_pkg::TX_BEAT1;
            end
            pcie_app_pkg::TX_BEAT1:
            begin
               if (tx_tready)
                  state <= two_beats ? pcie_app_pkg::TX_IDLE : pcie_app_pkg::TX_BEAT2;
            end
            default:
            begin
               if (tx_tready)
                  state <= pcie_app_pkg::TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (read_completion_ready)
      begin
         // byte count 8, successful status
         beat0 <= {pcie_id, 16'd8, pcie_app_pkg::FMT_CPLD, 14'h0, 10'd2};
         beat1 <= {read_completion_data[31:0], read_completion_rid_tag, 1'b0,
                   read_completion_lower_addr, 3'b000};
         beat2 <= {32'h0, read_completion_data[63:32]};
         two_beats <= 1'b0;
         half_last <= 1'b1;
         sending_write <= 1'b0;
      end
      else if (write_request_ready)
      begin
         beat0 <= {request_dw1, pcie_app_pkg::FMT_MWR64, 14'h0, 10'd2};
         beat1 <= {write_request_address[31:2], 2'b00, write_request_address[63:32]};
         beat2 <= write_request_data;
         two_beats <= 1'b0;
         half_last <= 1'b0;
         sending_write <= 1'b1;
      end
      else if (read_request_ready)
      begin
         beat0 <= {request_dw1, pcie_app_pkg::FMT_MRD64, 14'h0, 10'd2};
         beat1 <= {read_request_address[31:2], 2'b00, read_request_address[63:32]};
         two_beats <= 1'b1;
         half_last <= 1'b0;
         sending_write <= 1'b0;
      end
   end

   always_comb
   begin
      case (state)
         pcie_app_pkg::TX_BEAT1: tx_tdata = beat1;
         pcie_app_pkg::TX_BEAT2: tx_tdata = beat2;
         default:                tx_tdata = beat0;
      endcase
   end

   assign tx_tvalid = !idle;
   assign tx_tlast = (state == pcie_app_pkg::TX_BEAT1 && two_beats) ||
                     state == pcie_app_pkg::TX_BEAT2;
   // completion ends on a single DW
   assign tx_tkeep = (tx_tlast && half_last) ? 8'h0F : 8'hFF;
   assign write_request_accepted = tx_tready && tx_tlast && sending_write;

endmodule

// File: source/pcie_endpoint_app.sv
`timescale 1ns/10ps

module pcie_endpoint_app
(
   input  logic                   clock,
   input  logic                   reset,
   input  pcie_app_pkg::pcie_id_t pcie_id,
   input  logic                   rx_tvalid,
   input  logic                   rx_tlast,
   input  pcie_app_pkg::qword_t   rx_tdata,
   input  logic                   tx_tready,
   output logic                   tx_tvalid,
   output logic                   tx_tlast,
   output pcie_app_pkg::qword_t   tx_tdata,
   output logic [7:0]             tx_tkeep,
   output logic [3:0]             led
);

   logic                    write_valid;
   logic                    read_valid;
   logic                    completion_valid;
   pcie_app_pkg::reg_addr_t rx_address;
   pcie_app_pkg::qword_t    rx_data;
   pcie_app_pkg::rid_tag_t  rx_rid_tag;

   logic                    read_completion_valid;
   pcie_app_pkg::rid_tag_t  read_completion_rid_tag;
   logic [3:0]              read_completion_lower_addr;
   pcie_app_pkg::qword_t    read_completion_data;
   logic                    read_completion_ready;
   logic                    write_request_valid;
   pcie_app_pkg::qword_t    write_request_address;
   pcie_app_pkg::qword_t    write_request_data;
   logic                    write_request_ready;
   logic                    write_request_accepted;
   logic                    read_request_valid;
   pcie_app_pkg::qword_t    read_request_address;
   logic                    read_request_ready;

   tlp_receiver receiver
   (
      .clock(clock),
      .reset(reset),
      .rx_tvalid(rx_tvalid),
      .rx_tlast(rx_tlast),
      .rx_tdata(rx_tdata),
      .write_valid(write_valid),
      .read_valid(read_valid),
      .completion_valid(completion_valid),
      .address(rx_address),
      .data(rx_data),
      .rid_tag(rx_rid_tag)
   );

   bar_registers registers
   (
      .clock(clock),
      .reset(reset),
      .write_valid(write_valid),
      .read_valid(read_valid),
      .completion_valid(completion_valid),
      .address(rx_address),
      .data(rx_data),
      .rid_tag(rx_rid_tag),
      .read_completion_ready(read_completion_ready),
      .write_request_ready(write_request_ready),
      .write_request_accepted(write_request_accepted),
      .read_request_ready(read_request_ready),
      .led(led),
      .read_completion_valid(read_completion_valid),
      .read_completion_rid_tag(read_completion_rid_tag),
      .read_completion_lower_addr(read_completion_lower_addr),
      .read_completion_data(read_completion_data),
      .write_request_valid(write_request_valid),
      .write_request_address(write_request_address),
      .write_request_data(write_request_data),
      .read_request_valid(read_request_valid),
      .read_request_address(read_request_address)
   );

   tlp_transmitter transmitter
   (
      .clock(clock),
      .reset(reset),
      .pcie_id(pcie_id),
      .read_completion_valid(read_completion_valid),
      .read_completion_rid_tag(read_completion_rid_tag),
      .read_completion_lower_addr(read_completion_lower_addr),
      .read_completion_data(read_completion_data),
      .read_completion_ready(read_completion_ready),
      .write_request_valid(write_request_valid),
      .write_request_address(write_request_address),
      .write_request_data(write_request_data),
      .write_request_ready(write_request_ready),
      .write_request_accepted(write_request_accepted),
      .read_request_valid(read_request_valid),
      .read_request_address(read_request_address),
      .read_request_ready(read_request_ready),
      .tx_tready(tx_tready),
      .tx_tvalid(tx_tvalid),
      .tx_tlast(tx_tlast),
      .tx_tdata(tx_tdata),
      .tx_tkeep(tx_tkeep)
   );

endmodule

// File: tb/endpoint_props.sv
`timescale 1ns/10ps

module endpoint_props
(
   input logic                 clock,
   input logic                 reset,
   input logic                 tx_tvalid,
   input logic                 tx_tready,
   input logic                 tx_tlast,
   input pcie_app_pkg::qword_t tx_tdata,
   input logic [7:0]           tx_tkeep,
   input logic                 read_completion_ready,
   input logic                 write_request_ready,
   input logic                 read_request_ready
);

   logic request_taken;
   int   failure_count = 0;

   assign request_taken = read_completion_ready || write_request_ready || read_request_ready;

   // a stalled beat must not move
   stall_hold: assert property (@(posedge clock) disable iff (reset)
      tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) &&
      $stable(tx_tlast) && $stable(tx_tkeep))
      else
      begin
         failure_count++;
         $error("transmit beat changed while tready was low");
      end

   // one request latched per TLP, its first beat follows
   one_request: assert property (@(posedge clock) disable iff (reset)
      request_taken |=> tx_tvalid && !request_taken)
      else
      begin
         failure_count++;
         $error("request accepted without starting a single TLP");
      end

   // a TLP runs until its last beat transfers
   no_drop: assert property (@(posedge clock) disable iff (reset)
      tx_tvalid && !(tx_tready && tx_tlast) |=> tx_tvalid)
      else
      begin
         failure_count++;
         $error("transmit valid dropped before the last beat");
      end

endmodule

// File: tb/endpoint_checker.sv
`timescale 1ns/10ps

module endpoint_checker
(
   input logic                 clock,
   input logic                 reset,
   input logic                 tx_tvalid,
   input logic                 tx_tready,
   input logic                 tx_tlast,
   input pcie_app_pkg::qword_t tx_tdata,
   input logic [7:0]           tx_tkeep,
   input logic [3:0]           led
);

   string                exp_name[$];
   pcie_app_pkg::qword_t exp_beat0[$];
   pcie_app_pkg::qword_t exp_beat1[$];
   pcie_app_pkg::qword_t exp_beat2[$];
   int                   exp_beats[$];
   logic [7:0]           exp_keep[$];
   pcie_app_pkg::qword_t got[3];
   logic [7:0]           body_keep = 8'hFF;
   int                   beat_index = 0;
   int                   tlp_count = 0;
   int                   error_count = 0;

   task automatic expect_tlp(input string name, input pcie_app_pkg::qword_t b0,
                             input pcie_app_pkg::qword_t b1, input pcie_app_pkg::qword_t b2,
                             input int beats, input logic [7:0] keep);
      exp_name.push_back(name);
      exp_beat0.push_back(b0);
      exp_beat1.push_back(b1);
      exp_beat2.push_back(b2);
      exp_beats.push_back(beats);
      exp_keep.push_back(keep);
   endtask

   task automatic compare_value(input string name, input string what,
                                input pcie_app_pkg::qword_t expected,
                                input pcie_app_pkg::qword_t actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("** Error %s %s expected %h actual %h", name, what, expected, actual);
      end
   endtask

   task automatic check_led(input string name, input logic [3:0] expected);
      compare_value(name, "led", 64'(expected), 64'(led));
   endtask

   task automatic finish_tlp(input logic [7:0] last_keep);
      string name;
      int    beats;
      if (exp_name.size() == 0)
      begin
         error_count++;
         $display("an outbound TLP appeared that no test asked for");
         return;
      end
      name = exp_name.pop_front();
      beats = exp_beats.pop_front();
      compare_value(name, "beat count", 64'(beats), 64'(beat_index + 1));
      compare_value(name, "beat 0", exp_beat0.pop_front(), got[0]);
      compare_value(name, "beat 1", exp_beat1.pop_front(), got[1]);
      if (beats == 3)
         compare_value(name, "beat 2", exp_beat2.pop_front(), got[2]);
      else
         void'(exp_beat2.pop_front());
      compare_value(name, "body keep", 64'hFF, 64'(body_keep));
      compare_value(name, "last keep", 64'(exp_keep.pop_front()), 64'(last_keep));
      tlp_count++;
   endtask

   always @(posedge clock)
   begin
      if (!reset && tx_tvalid && tx_tready)
      begin
         if (beat_index < 3)
            got[beat_index] = tx_tdata;
         if (tx_tlast)
         begin
            finish_tlp(tx_tkeep);
            beat_index = 0;
            body_keep = 8'hFF;
         end
         else
         begin
            body_keep = body_keep & tx_tkeep;
            beat_index++;
         end
      end
   end

endmodule

// File: tb/tb_pcie_endpoint.sv
`timescale 1ns/10ps

module tb_pcie_endpoint;

   localparam int ROWS = 11;

   logic                   clock;
   logic                   reset;
   pcie_app_pkg::pcie_id_t pcie_id;
   logic                   rx_tvalid;
   logic                   rx_tlast;
   pcie_app_pkg::qword_t   rx_tdata;
   logic                   tx_tready;
   logic                   tx_tvalid;
   logic                   tx_tlast;
   pcie_app_pkg::qword_t   tx_tdata;
   logic [7:0]             tx_tkeep;
   logic [3:0]             led;
   integer                 seed;

   // row kinds 0 write, 1 read, 2 completion; outbound 0 none, 1 CplD, 2 MWr64, 3 MRd64
   string                   row_name[ROWS];
   int                      row_kind[ROWS];
   pcie_app_pkg::reg_addr_t row_reg[ROWS];
   pcie_app_pkg::qword_t    row_data[ROWS];
   pcie_app_pkg::rid_tag_t  row_rid[ROWS];
   int                      row_out[ROWS];
   pcie_app_pkg::qword_t    row_value[ROWS];
   logic [3:0]              row_led[ROWS];
   int                      rows_loaded = 0;
   int                      tlps_expected = 0;

   pcie_endpoint_app UUT
   (
      .clock(clock),
      .reset(reset),
      .pcie_id(pcie_id),
      .rx_tvalid(rx_tvalid),
      .rx_tlast(rx_tlast),
      .rx_tdata(rx_tdata),
      .tx_tready(tx_tready),
      .tx_tvalid(tx_tvalid),
      .tx_tlast(tx_tlast),
      .tx_tdata(tx_tdata),
      .tx_tkeep(tx_tkeep),
      .led(led)
   );

   endpoint_checker monitor
   (
      .clock(clock),
      .reset(reset),
      .tx_tvalid(tx_tvalid),
      .tx_tready(tx_tready),
      .tx_tlast(tx_tlast),
      .tx_tdata(tx_tdata),
      .tx_tkeep(tx_tkeep),
      .led(led)
   );

   bind tlp_transmitter endpoint_props props
   (
      .clock(clock),
      .reset(reset),
      .tx_tvalid(tx_tvalid),
      .tx_tready(tx_tready),
      .tx_tlast(tx_tlast),
      .tx_tdata(tx_tdata),
      .tx_tkeep(tx_tkeep),
      .read_completion_ready(read_completion_ready),
      .write_request_ready(write_request_ready),
      .read_request_ready(read_request_ready)
   );

   initial
   begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // ready about three cycles in four
   always @(posedge clock)
      tx_tready <= ($random(seed) & 3) != 0;

   task automatic add_row(input string name, input int kind, input pcie_app_pkg::reg_addr_t ra,
                          input pcie_app_pkg::qword_t value_in, input pcie_app_pkg::rid_tag_t rid,
                          input int out_kind, input pcie_app_pkg::qword_t expected,
                          input logic [3:0] led_value);
      row_name[rows_loaded] = name;
      row_kind[rows_loaded] = kind;
      row_reg[rows_loaded] = ra;
      row_data[rows_loaded] = value_in;
      row_rid[rows_loaded] = rid;
      row_out[rows_loaded] = out_kind;
      row_value[rows_loaded] = expected;
      row_led[rows_loaded] = led_value;
      rows_loaded++;
   endtask

   task automatic load_table();
      add_row("scratch_write", 0, 13'd0, 64'h1122334455667789, 24'h010001, 0, 64'h0, 4'h9);
      add_row("scratch_read", 1, 13'd0, 64'h0, 24'h010007, 1, 64'h1122334455667789, 4'h9);
      add_row("write_launch_a", 0, 13'd100, 64'h0000000123456780, 24'h010002, 2, 64'h100, 4'h0);
      add_row("write_launch_b", 0, 13'd100, 64'h00000000ABCD0008, 24'h010003, 2, 64'h101, 4'h8);
      add_row("read_launch", 0, 13'd101, 64'h0000000200001000, 24'h010004, 3, 64'h0, 4'h0);
      add_row("completion_in", 2, 13'd0, 64'hCAFEF00D12345678, 24'h0A1000, 0, 64'h0, 4'h0);
      add_row("scratch_after_cpl", 1, 13'd0, 64'h0, 24'h020011, 1, 64'hCAFEF00D12345678, 4'h0);
      add_row("cpld_count", 1, 13'd1, 64'h0, 24'h020012, 1, 64'd1, 4'h0);
      add_row("write_count", 1, 13'd2, 64'h0, 24'h020013, 1, 64'd4, 4'h0);
      add_row("read_count", 1, 13'd3, 64'h0, 24'h020014, 1, 64'd5, 4'h0);
      add_row("unmapped_read", 1, 13'h25, 64'h0, 24'h030015, 1, 64'h00000025DEADBEEF, 4'h0);
   endtask

   task automatic send_row(input int row);
      logic [7:0] fmt;
      fmt = row_kind[row] == 0 ? 8'h40 : (row_kind[row] == 1 ? 8'h00 : 8'h4A);
      @(posedge clock);
      rx_tvalid <= 1'b1;
      rx_tlast <= 1'b0;
      rx_tdata <= {row_rid[row], 8'hFF, fmt, 14'h0, 10'd2};
      @(posedge clock);
      rx_tlast <= row_kind[row] == 1;
      // completions carry requester id and tag in DW2
      if (row_kind[row] == 2)
         rx_tdata <= {row_data[row][31:0], row_rid[row], 8'h00};
      else
         rx_tdata <= {row_data[row][31:0], 16'h0, row_reg[row], 3'b000};
      if (row_kind[row] != 1)
      begin
         @(posedge clock);
         rx_tlast <= 1'b1;
         rx_tdata <= {32'h0, row_data[row][63:32]};
      end
      @(posedge clock);
      rx_tvalid <= 1'b0;
      rx_tlast <= 1'b0;
   endtask

   task automatic queue_expected(input int row);
      pcie_app_pkg::qword_t target;
      logic [31:0]          request_dw1;
      target = row_data[row];
      request_dw1 = {pcie_id, 8'h00, 8'hFF};
      if (row_out[row] == 1)
         monitor.expect_tlp(row_name[row], {pcie_id, 16'd8, 8'h4A, 14'h0, 10'd2},
                            {row_value[row][31:0], row_rid[row], 1'b0, row_reg[row][3:0], 3'b0},
                            {32'h0, row_value[row][63:32]}, 3, 8'h0F);
      else if (row_out[row] == 2)
         monitor.expect_tlp(row_name[row], {request_dw1, 8'h60, 14'h0, 10'd2},
                            {target[31:2], 2'b00, target[63:32]}, row_value[row], 3, 8'hFF);
      else
         monitor.expect_tlp(row_name[row], {request_dw1, 8'h20, 14'h0, 10'd2},
                            {target[31:2], 2'b00, target[63:32]}, 64'h0, 2, 8'hFF);
   endtask

   initial
   begin
      int row;
      int wait_cycles;
      seed = 32'h5c2902f4;
      reset = 1'b1;
      pcie_id = 16'h0A10;
      rx_tvalid = 1'b0;
      rx_tlast = 1'b0;
      rx_tdata = '0;
      tx_tready = 1'b0;
      load_table();
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      for (row = 0; row < rows_loaded; row++)
      begin
         if (row_out[row] != 0)
         begin
            queue_expected(row);
            tlps_expected++;
         end
         send_row(row);
         // strobe, then register update
         repeat (3) @(posedge clock);
         monitor.check_led(row_name[row], row_led[row]);
         wait_cycles = 0;
         while (monitor.tlp_count < tlps_expected && wait_cycles < 200)
         begin
            @(posedge clock);
            wait_cycles++;
         end
         if (monitor.tlp_count < tlps_expected)
         begin
            $display("timeout: test %s never produced its outbound TLP", row_name[row]);
            $display(">>> FAIL");
            $finish;
         end
      end
      repeat (20) @(posedge clock);
      $display("tests %0d, TLPs %0d, errors %0d, assertion failures %0d", rows_loaded,
               monitor.tlp_count, monitor.error_count, UUT.transmitter.props.failure_count);
      if (monitor.error_count == 0 && monitor.tlp_count == tlps_expected &&
          UUT.transmitter.props.failure_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: sim.f
source/pcie_app_pkg.sv
source/tlp_receiver.sv
source/bar_registers.sv
source/tlp_transmitter.sv
source/pcie_endpoint_app.sv
tb/endpoint_props.sv
tb/endpoint_checker.sv
tb/tb_pcie_endpoint.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_pcie_endpoint -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_pcie_endpoint)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
